//--- hdl/io_pkg.sv
package io_pkg;

  // bus and port widths
  localparam int data_width       = 16; // one i/o word
  localparam int slot_bits        = 2;  // hardware thread id
  localparam int num_slots        = 4;  // slots 0..3, slot 0 never gets a task
  localparam int led_bits         = 8;
  localparam int sample_addr_bits = 8;  // 256 word sample memory
  localparam int kill_bits        = 4;  // one kill request bit per slot

  // sample_ctrl write bits, pointer value comes from data[7:0]
  localparam int ctrl_set_wptr = 11;
  localparam int ctrl_set_rptr = 10;

  // register index, taken straight from the 4-bit bus address
  typedef enum logic [3:0] {
    reg_gpio        = 4'd0,  // port data, reads merge inputs
    reg_dir         = 4'd1,  // 1 = output
    reg_leds        = 4'd2,
    reg_task1       = 4'd3,  // task word for slot 1
    reg_task2       = 4'd4,
    reg_task3       = 4'd5,
    reg_sample      = 4'd6,  // sample memory data, pointers auto-increment
    reg_sample_ctrl = 4'd7,  // pointer set / readback
    reg_task_fetch  = 4'd8,  // read: own task, write: kill request
    reg_mask_ticks  = 4'd9   // read: wall clock, write: one-shot mask
  } io_reg_t;

endpackage

//--- hdl/wb_io_frontend.sv
module wb_io_frontend (
  input  logic                             clk,
  input  logic                             resetq,
  // wishbone classic slave
  input  logic                             cyc,
  input  logic                             stb,
  input  logic                             we,
  input  logic [3:0]                       adr,
  input  logic [io_pkg::data_width-1:0]    dat_w,
  input  logic [io_pkg::slot_bits-1:0]     slot,
  output logic                             ack,
  output logic [io_pkg::data_width-1:0]    dat_r,
  // read values from the register blocks
  input  logic [io_pkg::data_width-1:0]    gpio_rd,
  input  logic [io_pkg::data_width-1:0]    dir_rd,
  input  logic [io_pkg::data_width-1:0]    leds_rd,
  input  logic [io_pkg::data_width-1:0]    task_rd,
  input  logic [io_pkg::data_width-1:0]    sample_rd,
  // internal strobes, valid together with ack
  output logic                             wr_stb,
  output logic                             rd_stb,
  output io_pkg::io_reg_t                  reg_sel,
  output logic [io_pkg::data_width-1:0]    wdata,
  output logic [io_pkg::data_width-1:0]    wmask,
  output logic [io_pkg::slot_bits-1:0]     slot_q
);

  logic [io_pkg::data_width-1:0] mask_q [io_pkg::num_slots]; // one-shot mask per slot
  logic [io_pkg::data_width-1:0] ticks;                      // wall clock
  logic                          req;

  // new request; the access already being acked must not start another
  assign req = cyc & stb & ~ack;

  always_ff @(posedge clk) begin
    if (!resetq) begin
      ack    <= 1'b0;
      wr_stb <= 1'b0;
      rd_stb <= 1'b0;
    end else begin
      ack    <= req;       // exactly one cycle, never stretched
      wr_stb <= req & we;
      rd_stb <= req & ~we;
    end
  end

  // request payload, held through the ack cycle
  always_ff @(posedge clk) begin
    if (req) begin
      reg_sel <= io_pkg::io_reg_t'(adr);
      wdata   <= dat_w;
      slot_q  <= slot;
      wmask   <= mask_q[slot]; // preset left by this slot's last mask write
    end
  end

  // mask write arms the slot's mask, any other access by it uses it up
  always_ff @(posedge clk) begin
    if (!resetq) begin
      for (int i = 0; i < io_pkg::num_slots; i++) begin
        mask_q[i] <= '1;
      end
    end else if (wr_stb | rd_stb) begin
      if (wr_stb && reg_sel == io_pkg::reg_mask_ticks)
        mask_q[slot_q] <= wdata;
      else
        mask_q[slot_q] <= '1; // back to unmasked
    end
  end

  always_ff @(posedge clk) begin
    if (!resetq)
      ticks <= '0;
    else
      ticks <= ticks + 1'b1; // free running, wraps
  end

  // read data select, registered index keeps it stable during ack
  always_comb begin
    case (reg_sel)
      io_pkg::reg_gpio:        dat_r = gpio_rd;
      io_pkg::reg_dir:         dat_r = dir_rd;
      io_pkg::reg_leds:        dat_r = leds_rd;
      io_pkg::reg_task1,
      io_pkg::reg_task2,
      io_pkg::reg_task3,
      io_pkg::reg_task_fetch:  dat_r = task_rd;
      io_pkg::reg_sample,
      io_pkg::reg_sample_ctrl: dat_r = sample_rd;
      io_pkg::reg_mask_ticks:  dat_r = ticks;
      default:                 dat_r = '0; // unused indexes read zero
    endcase
  end

endmodule

//--- hdl/gpio_port.sv
module gpio_port (
  input  logic                          clk,
  input  logic                          resetq,
  input  logic                          wr_stb,
  input  io_pkg::io_reg_t               reg_sel,
  input  logic [io_pkg::data_width-1:0] wdata,
  input  logic [io_pkg::data_width-1:0] wmask,
  input  logic [io_pkg::data_width-1:0] gpio_in,
  output logic [io_pkg::data_width-1:0] gpio_out,
  output logic [io_pkg::data_width-1:0] gpio_oe,
  output logic [io_pkg::led_bits-1:0]   leds,
  output logic [io_pkg::data_width-1:0] gpio_rd,
  output logic [io_pkg::data_width-1:0] dir_rd,
  output logic [io_pkg::data_width-1:0] leds_rd
);

  logic [io_pkg::data_width-1:0] out_q; // output data register
  logic [io_pkg::data_width-1:0] dir_q; // 1 = pin drives
  logic [io_pkg::led_bits-1:0]   leds_q;

  // only bits set in the mask take the new value
  function automatic logic [io_pkg::data_width-1:0] merge(
    input logic [io_pkg::data_width-1:0] old_val,
    input logic [io_pkg::data_width-1:0] new_val,
    input logic [io_pkg::data_width-1:0] mask
  );
    return (new_val & mask) | (old_val & ~mask);
  endfunction

  always_ff @(posedge clk) begin
    if (!resetq) begin
      out_q  <= '0;
      dir_q  <= '0;   // all inputs after reset
      leds_q <= '0;
    end else if (wr_stb) begin
      case (reg_sel)
        io_pkg::reg_gpio: out_q <= merge(out_q, wdata, wmask);
        io_pkg::reg_dir:  dir_q <= merge(dir_q, wdata, wmask);
        io_pkg::reg_leds: leds_q <= wdata[io_pkg::led_bits-1:0] & wmask[io_pkg::led_bits-1:0]
                                  | leds_q & ~wmask[io_pkg::led_bits-1:0];
        default: ;
      endcase
    end
  end

  assign gpio_out = out_q;
  assign gpio_oe  = dir_q;
  assign leds     = leds_q;

  // input pins read the pad, output pins read back the register
  assign gpio_rd = (gpio_in & ~dir_q) | (out_q & dir_q);
  assign dir_rd  = dir_q;
  assign leds_rd = {{(io_pkg::data_width - io_pkg::led_bits){1'b0}}, leds_q};

endmodule

//--- hdl/task_scheduler.sv
module task_scheduler (
  input  logic                          clk,
  input  logic                          resetq,
  input  logic                          wr_stb,
  input  logic                          rd_stb,
  input  io_pkg::io_reg_t               reg_sel,
  input  logic [io_pkg::data_width-1:0] wdata,
  input  logic [io_pkg::slot_bits-1:0]  slot_q,
  output logic [io_pkg::data_width-1:0] task_rd,
  output logic [io_pkg::kill_bits-1:0]  kill_slot
);

  // task xt per slot, slot 0 has none; bit 0 set means run once
  logic [io_pkg::data_width-1:0] task_q [1:io_pkg::num_slots-1];
  logic                          own_task; // access comes from a slot that owns a task word

  assign own_task = (slot_q != '0);

  always_ff @(posedge clk) begin
    if (!resetq) begin
      for (int i = 1; i < io_pkg::num_slots; i++) begin
        task_q[i] <= '0;
      end
      kill_slot <= '0;
    end else begin
      kill_slot <= '0; // single cycle request
      if (wr_stb) begin
        case (reg_sel)
          io_pkg::reg_task1:      task_q[1] <= wdata;
          io_pkg::reg_task2:      task_q[2] <= wdata;
          io_pkg::reg_task3:      task_q[3] <= wdata;
          io_pkg::reg_task_fetch: kill_slot <= wdata[io_pkg::kill_bits-1:0];
          default: ;
        endcase
      end else if (rd_stb && reg_sel == io_pkg::reg_task_fetch && own_task) begin
        if (task_q[slot_q][0])
          task_q[slot_q] <= '0; // run-once task gone after its fetch
      end
    end
  end

  always_comb begin
    case (reg_sel)
      io_pkg::reg_task1: task_rd = task_q[1];
      io_pkg::reg_task2: task_rd = task_q[2];
      io_pkg::reg_task3: task_rd = task_q[3];
      io_pkg::reg_task_fetch: begin
        // valid xts are even, slot 0 just spins on zero
        if (own_task)
          task_rd = {task_q[slot_q][io_pkg::data_width-1:1], 1'b0};
        else
          task_rd = '0;
      end
      default: task_rd = '0;
    endcase
  end

endmodule

//--- hdl/sample_buffer.sv
module sample_buffer (
  input  logic                          clk,
  input  logic                          resetq,
  input  logic                          wr_stb,
  input  logic                          rd_stb,
  input  io_pkg::io_reg_t               reg_sel,
  input  logic [io_pkg::data_width-1:0] wdata,
  output logic [io_pkg::data_width-1:0] sample_rd
);

  localparam int depth = 1 << io_pkg::sample_addr_bits;

  logic [io_pkg::data_width-1:0]       mem [depth];
  logic [io_pkg::data_width-1:0]       rdata_q;  // word at the read pointer
  logic [io_pkg::sample_addr_bits-1:0] wptr;
  logic [io_pkg::sample_addr_bits-1:0] rptr;
  logic                                sample_wr;
  logic                                sample_rd_hit;
  logic                                ctrl_wr;

  assign sample_wr     = wr_stb && reg_sel == io_pkg::reg_sample;
  assign sample_rd_hit = rd_stb && reg_sel == io_pkg::reg_sample;
  assign ctrl_wr       = wr_stb && reg_sel == io_pkg::reg_sample_ctrl;

  always_ff @(posedge clk) begin
    if (!resetq) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      // pointer load wins over the increment
      if (ctrl_wr && wdata[io_pkg::ctrl_set_wptr])
        wptr <= wdata[io_pkg::sample_addr_bits-1:0];
      else if (sample_wr)
        wptr <= wptr + 1'b1;

      if (ctrl_wr && wdata[io_pkg::ctrl_set_rptr])
        rptr <= wdata[io_pkg::sample_addr_bits-1:0];
      else if (sample_rd_hit)
        rptr <= rptr + 1'b1;
    end
  end

  // inferred block ram, read port runs every cycle
  always_ff @(posedge clk) begin
    if (sample_wr)
      mem[wptr] <= wdata;
    rdata_q <= mem[rptr]; // settles well before the next ack
  end

  // ctrl readback: write pointer high byte, read pointer low byte
  assign sample_rd = (reg_sel == io_pkg::reg_sample_ctrl) ? {wptr, rptr} : rdata_q;

endmodule

//--- hdl/io_subsystem.sv
module io_subsystem (
  input  logic                          clk,
  input  logic                          resetq,
  // wishbone classic slave, slot tags the accessing thread
  input  logic                          cyc,
  input  logic                          stb,
  input  logic                          we,
  input  logic [3:0]                    adr,
  input  logic [io_pkg::data_width-1:0] dat_w,
  input  logic [io_pkg::slot_bits-1:0]  slot,
  output logic [io_pkg::data_width-1:0] dat_r,
  output logic                          ack,
  // pins
  input  logic [io_pkg::data_width-1:0] gpio_in,
  output logic [io_pkg::data_width-1:0] gpio_out,
  output logic [io_pkg::data_width-1:0] gpio_oe,
  output logic [io_pkg::led_bits-1:0]   leds,
  output logic [io_pkg::kill_bits-1:0]  kill_slot
);

  logic                          wr_stb;
  logic                          rd_stb;
  io_pkg::io_reg_t               reg_sel;
  logic [io_pkg::data_width-1:0] wdata;
  logic [io_pkg::data_width-1:0] wmask;   // per-slot one-shot mask
  logic [io_pkg::slot_bits-1:0]  slot_q;
  logic [io_pkg::data_width-1:0] gpio_rd;
  logic [io_pkg::data_width-1:0] dir_rd;
  logic [io_pkg::data_width-1:0] leds_rd;
  logic [io_pkg::data_width-1:0] task_rd;
  logic [io_pkg::data_width-1:0] sample_rd;

  wb_io_frontend u_frontend (
    .clk(clk), .resetq(resetq),
    .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .slot(slot),
    .ack(ack), .dat_r(dat_r),
    .gpio_rd(gpio_rd), .dir_rd(dir_rd), .leds_rd(leds_rd),
    .task_rd(task_rd), .sample_rd(sample_rd),
    .wr_stb(wr_stb), .rd_stb(rd_stb), .reg_sel(reg_sel),
    .wdata(wdata), .wmask(wmask), .slot_q(slot_q)
  );

  gpio_port u_gpio (
    .clk(clk), .resetq(resetq),
    .wr_stb(wr_stb), .reg_sel(reg_sel), .wdata(wdata), .wmask(wmask),
    .gpio_in(gpio_in), .gpio_out(gpio_out), .gpio_oe(gpio_oe), .leds(leds),
    .gpio_rd(gpio_rd), .dir_rd(dir_rd), .leds_rd(leds_rd)
  );

  task_scheduler u_tasks (
    .clk(clk), .resetq(resetq),
    .wr_stb(wr_stb), .rd_stb(rd_stb), .reg_sel(reg_sel), .wdata(wdata),
    .slot_q(slot_q), .task_rd(task_rd), .kill_slot(kill_slot)
  );

  sample_buffer u_samples (
    .clk(clk), .resetq(resetq),
    .wr_stb(wr_stb), .rd_stb(rd_stb), .reg_sel(reg_sel), .wdata(wdata),
    .sample_rd(sample_rd)
  );

endmodule

//--- verification/tb_io_subsystem.sv
module tb_io_subsystem;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ack_timeout = 16; // cycles allowed per ack
  localparam int tick_gap    = 6;  // accesses between the two wall clock reads

  logic                          clk;
  logic                          resetq;
  logic                          cyc;
  logic                          stb;
  logic                          we;
  logic [3:0]                    adr;
  logic [io_pkg::data_width-1:0] dat_w;
  logic [io_pkg::slot_bits-1:0]  slot;
  logic [io_pkg::data_width-1:0] dat_r;
  logic                          ack;
  logic [io_pkg::data_width-1:0] gpio_in;
  logic [io_pkg::data_width-1:0] gpio_out;
  logic [io_pkg::data_width-1:0] gpio_oe;
  logic [io_pkg::led_bits-1:0]   leds;
  logic [io_pkg::kill_bits-1:0]  kill_slot;

  // reference model state
  logic [15:0] lfsr = 16'd73;
  logic [15:0] out_m;
  logic [15:0] dir_m;
  logic [7:0]  leds_m;
  logic [15:0] mask_m [4];
  logic [15:0] task_m [4];  // entry 0 unused, slot 0 owns no task
  logic [7:0]  wptr_m;
  logic [7:0]  rptr_m;
  logic [15:0] mem_m [256];
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          bad_tests = 0;
  int          test_errors = 0;

  io_subsystem DUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1); // galois form with taps 16 14 13 11
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr); // one step per bit
      v = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [1:0] rand_slot();
    logic [15:0] v;
    v = rand_bits(2);
    return v[1:0];
  endfunction

  // applies one access to the model, returns the expected read data
  function automatic logic [15:0] model_access(input io_pkg::io_reg_t r, input logic w,
                                               input logic [15:0] d, input logic [1:0] s);
    logic [15:0] m;
    logic [15:0] rv;
    m  = mask_m[s];
    rv = '0;
    mask_m[s] = (w && r == io_pkg::reg_mask_ticks) ? d : 16'hffff; // one shot
    if (w) begin
      case (r)
        io_pkg::reg_gpio:  out_m = (d & m) | (out_m & ~m);
        io_pkg::reg_dir:   dir_m = (d & m) | (dir_m & ~m);
        io_pkg::reg_leds:  leds_m = (d[7:0] & m[7:0]) | (leds_m & ~m[7:0]);
        io_pkg::reg_task1: task_m[1] = d;
        io_pkg::reg_task2: task_m[2] = d;
        io_pkg::reg_task3: task_m[3] = d;
        io_pkg::reg_sample: begin
          mem_m[wptr_m] = d;
          wptr_m = wptr_m + 8'd1;
        end
        io_pkg::reg_sample_ctrl: begin
          if (d[io_pkg::ctrl_set_wptr])
            wptr_m = d[7:0];
          if (d[io_pkg::ctrl_set_rptr])
            rptr_m = d[7:0];
        end
        default: ;
      endcase
    end else begin
      case (r)
        io_pkg::reg_gpio:        rv = (gpio_in & ~dir_m) | (out_m & dir_m);
        io_pkg::reg_dir:         rv = dir_m;
        io_pkg::reg_leds:        rv = {8'h00, leds_m};
        io_pkg::reg_task1:       rv = task_m[1];
        io_pkg::reg_task2:       rv = task_m[2];
        io_pkg::reg_task3:       rv = task_m[3];
        io_pkg::reg_sample_ctrl: rv = {wptr_m, rptr_m};
        io_pkg::reg_sample: begin
          rv = mem_m[rptr_m];
          rptr_m = rptr_m + 8'd1;
        end
        io_pkg::reg_task_fetch: begin
          if (s != 2'd0) begin
            rv = {task_m[s][15:1], 1'b0};
            if (task_m[s][0])
              task_m[s] = '0; // run once
          end
        end
        default: ;
      endcase
    end
    return rv;
  endfunction

  task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s got 0x%04h expected 0x%04h", name, got, exp);
    end
  endtask

  // request is held until ack, dropped on the edge that ends the ack cycle
  task automatic bus_access(input io_pkg::io_reg_t r, input logic w, input logic [15:0] d,
                            input logic [1:0] s, output logic [15:0] rdata);
    int waited;
    waited = 0;
    rdata  = '0;
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= w;
    adr   <= r;
    dat_w <= d;
    slot  <= s;
    @(negedge clk);
    while (!ack && waited < ack_timeout) begin
      waited++;
      @(negedge clk);
    end
    if (ack) begin
      rdata = dat_r; // stable mid cycle
    end else begin
      errors++;
      $display("bus access to register %0d got no ack", r);
    end
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic bus_write(input io_pkg::io_reg_t r, input logic [15:0] d, input logic [1:0] s);
    logic [15:0] unused_rd;
    bus_access(r, 1'b1, d, s, unused_rd);
  endtask

  task automatic bus_read(input io_pkg::io_reg_t r, input logic [1:0] s,
                          output logic [15:0] rdata);
    bus_access(r, 1'b0, 16'h0000, s, rdata);
  endtask

  task automatic write_reg(input io_pkg::io_reg_t r, input logic [15:0] d, input logic [1:0] s);
    bus_write(r, d, s);
    void'(model_access(r, 1'b1, d, s));
  endtask

  task automatic read_check(input io_pkg::io_reg_t r, input logic [1:0] s, input string name);
    logic [15:0] got;
    bus_read(r, s, got);
    check_value(name, got, model_access(r, 1'b0, 16'h0000, s));
  endtask

  task automatic check_pins();
    @(negedge clk); // new register values show one cycle after the strobe edge
    check_value("gpio_out", gpio_out, out_m);
    check_value("gpio_oe", gpio_oe, dir_m);
    check_value("leds", {8'h00, leds}, {8'h00, leds_m});
  endtask

  task automatic set_gpio_in(input logic [15:0] v);
    @(posedge clk);
    gpio_in <= v;
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == test_errors) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      bad_tests++;
      $display("test %0d %s: %0d errors", tests, name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  initial begin
    logic [1:0]  s;
    logic [1:0]  o;
    logic [15:0] d;
    logic [15:0] t1;
    logic [15:0] t2;
    int          diff;
    resetq  = 1'b0;
    cyc     = 1'b0;
    stb     = 1'b0;
    we      = 1'b0;
    adr     = 4'h0;
    dat_w   = '0;
    slot    = '0;
    gpio_in = '0;
    out_m   = '0;
    dir_m   = '0;
    leds_m  = '0;
    wptr_m  = '0;
    rptr_m  = '0;
    for (int i = 0; i < 4; i++) begin
      mask_m[i] = 16'hffff; // all slots unmasked out of reset
      task_m[i] = '0;
    end
    repeat (5) @(posedge clk);
    resetq <= 1'b1;

    check_pins();
    check_value("kill_slot", {12'h000, kill_slot}, 16'h0000);
    check_value("ack", {15'h0000, ack}, 16'h0000);
    read_check(io_pkg::reg_task1, 2'd0, "dat_r task1");
    read_check(io_pkg::reg_task2, 2'd0, "dat_r task2");
    read_check(io_pkg::reg_task3, 2'd0, "dat_r task3");
    read_check(io_pkg::reg_sample_ctrl, 2'd0, "dat_r sample_ctrl");
    finish_test("reset values");

    for (int i = 0; i < 8; i++) begin
      write_reg(io_pkg::reg_dir, rand_bits(16), rand_slot());
      write_reg(io_pkg::reg_gpio, rand_bits(16), rand_slot());
      write_reg(io_pkg::reg_leds, rand_bits(16), rand_slot());
      set_gpio_in(rand_bits(16)); // input pins merge into gpio reads
      read_check(io_pkg::reg_gpio, rand_slot(), "dat_r gpio");
      read_check(io_pkg::reg_dir, rand_slot(), "dat_r dir");
      read_check(io_pkg::reg_leds, rand_slot(), "dat_r leds");
      check_pins();
    end
    finish_test("gpio");

    for (int i = 0; i < 4; i++) begin
      s = rand_slot();
      o = s + 2'd1;
      write_reg(io_pkg::reg_mask_ticks, rand_bits(16), s); // arm s
      write_reg(io_pkg::reg_gpio, rand_bits(16), o);       // other slot stays unmasked
      check_pins();
      write_reg(io_pkg::reg_gpio, rand_bits(16), s);       // masked
      check_pins();
      write_reg(io_pkg::reg_gpio, rand_bits(16), s);       // mask used up
      check_pins();
    end
    finish_test("mask preset");

    for (int r = 0; r < 2; r++) begin
      for (int k = 1; k < 4; k++) begin
        d = rand_bits(16);
        d[0] = k[0] ^ r[0]; // mix of run-once and persistent tasks
        write_reg(io_pkg::io_reg_t'(4'(k + 2)), d, rand_slot());
      end
      for (int q = 0; q < 4; q++)
        read_check(io_pkg::reg_task_fetch, 2'(q), "dat_r task_fetch");
      for (int k = 1; k < 4; k++)
        read_check(io_pkg::io_reg_t'(4'(k + 2)), 2'd0, "dat_r task word");
      d = rand_bits(4);
      write_reg(io_pkg::reg_task_fetch, d, rand_slot());
      @(negedge clk);
      check_value("kill_slot", {12'h000, kill_slot}, d);
      @(negedge clk);
      check_value("kill_slot", {12'h000, kill_slot}, 16'h0000); // one cycle only
    end
    finish_test("task scheduler");

    d = rand_bits(8);
    write_reg(io_pkg::reg_sample_ctrl, 16'h0c00 | d, rand_slot()); // both pointers
    for (int i = 0; i < 12; i++)
      write_reg(io_pkg::reg_sample, rand_bits(16), rand_slot());
    read_check(io_pkg::reg_sample_ctrl, rand_slot(), "dat_r sample_ctrl");
    for (int i = 0; i < 12; i++)
      read_check(io_pkg::reg_sample, rand_slot(), "dat_r sample");
    write_reg(io_pkg::reg_sample_ctrl, 16'h0800 | rand_bits(8), rand_slot()); // wptr only
    read_check(io_pkg::reg_sample_ctrl, rand_slot(), "dat_r sample_ctrl");
    bus_read(io_pkg::reg_mask_ticks, 2'd1, t1);
    void'(model_access(io_pkg::reg_mask_ticks, 1'b0, 16'h0000, 2'd1));
    for (int i = 0; i < tick_gap; i++)
      read_check(io_pkg::reg_sample_ctrl, rand_slot(), "dat_r sample_ctrl");
    bus_read(io_pkg::reg_mask_ticks, 2'd1, t2);
    void'(model_access(io_pkg::reg_mask_ticks, 1'b0, 16'h0000, 2'd1));
    diff = {16'h0000, t2 - t1};
    checks++;
    if (diff == 0 || diff >= tick_gap * ack_timeout) begin
      errors++;
      $display("wall clock advanced by %0d ticks over %0d accesses", diff, tick_gap);
    end
    finish_test("sample buffer and wall clock");

    $display("tests %0d, tests with errors %0d, checks %0d, errors %0d",
             tests, bad_tests, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
hdl/io_pkg.sv
hdl/wb_io_frontend.sv
hdl/gpio_port.sv
hdl/task_scheduler.sv
hdl/sample_buffer.sv
hdl/io_subsystem.sv
verification/tb_io_subsystem.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = tb_io_subsystem
FILELIST  = sources.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
